/* design/lsu_replay_consts.svh */
/*
 * LSU replay path constants
 * Queue depth and the field widths shared by the replay queue blocks
 */

`ifndef LSU_REPLAY_CONSTS_SVH
`define LSU_REPLAY_CONSTS_SVH

// --------------------
// Queue geometry
// --------------------
`define LSU_RQ_DEPTH 8
`define LSU_RQ_PTR_W 3

// --------------------
// Payload widths
// --------------------
`define LSU_PADDR_W 34
`define LSU_INST_W 32
`define LSU_CMT_ID_W 6

// One mask bit per branch tag
`define LSU_BR_TAGS 4

// One-hot index with one bit per miss unit entry
`define LSU_MISSU_ENTRIES 4

`endif

/* design/lsu_replay_pkg.sv */
/*
 * LSU replay types
 * Width typedefs and the hazard type encoding
 */

`include "lsu_replay_consts.svh"

package lsu_replay_pkg;

    // --------------------
    // Payload vectors
    // --------------------
    typedef logic [`LSU_PADDR_W-1:0] paddr_t;
    typedef logic [`LSU_INST_W-1:0] inst_t;
    typedef logic [`LSU_CMT_ID_W-1:0] cmt_id_t;

    // Branch dependence with bit n set when the op sits under tag n
    typedef logic [`LSU_BR_TAGS-1:0] brmask_t;

    // Miss unit entry the op waits on
    typedef logic [`LSU_MISSU_ENTRIES-1:0] missu_oh_t;

    // Also used for the pacing counters
    typedef logic [`LSU_RQ_PTR_W-1:0] rq_ptr_t;

    // --------------------
    // Hazard types
    // --------------------
    typedef enum logic [2:0] {
        HAZ_STQ_NONFWD     = 3'd0,
        HAZ_RMW_ORDER      = 3'd1,
        HAZ_L1D_CONFLICT   = 3'd2,
        HAZ_MISSU_FULL     = 3'd3,
        HAZ_MISSU_ASSIGNED = 3'd4
    } haz_t;

endpackage

/* design/ring_fifo.sv */
/*
 * Ring FIFO
 * Circular buffer with occupancy count, head entry shown on o_data
 */

`timescale 1ns/1ps

module ring_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0] r_head;
    logic [PTR_W-1:0] r_tail;
    logic [CNT_W-1:0] r_count;
    logic             w_push_ok;
    logic             w_pop_ok;

    // Overflow and underflow requests are dropped
    assign w_push_ok = i_push & ~o_full;
    assign w_pop_ok  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (w_push_ok) begin
            r_mem[r_tail] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_head  <= '0;
            r_tail  <= '0;
            r_count <= '0;
        end else begin
            if (w_push_ok) begin
                r_tail <= (r_tail == PTR_LAST) ? '0 : r_tail + 1'b1;
            end
            if (w_pop_ok) begin
                r_head <= (r_head == PTR_LAST) ? '0 : r_head + 1'b1;
            end
            case ({w_push_ok, w_pop_ok})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    assign o_data  = r_mem[r_head];
    assign o_empty = (r_count == '0);
    assign o_full  = (r_count == CNT_W'(DEPTH));

endmodule

/* design/replay_entry_tags.sv */
/*
 * Replay entry tags
 * Per-slot valid, dead, commit id and branch mask with flush marking
 */

`timescale 1ns/1ps

`include "lsu_replay_consts.svh"

module replay_entry_tags #(
    parameter int DEPTH = `LSU_RQ_DEPTH
) (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          i_push,
    input  lsu_replay_pkg::rq_ptr_t       i_push_ptr,
    input  lsu_replay_pkg::cmt_id_t       i_push_cmt_id,
    input  lsu_replay_pkg::brmask_t       i_push_br_mask,
    input  logic                          i_pop,
    input  lsu_replay_pkg::rq_ptr_t       i_pop_ptr,
    input  logic                          i_commit_flush,
    input  logic                          i_br_update,
    input  logic [$clog2(`LSU_BR_TAGS)-1:0] i_br_tag,
    input  logic                          i_br_mispredict,
    output logic                          o_head_dead,
    output lsu_replay_pkg::cmt_id_t       o_head_cmt_id,
    output lsu_replay_pkg::brmask_t       o_head_br_mask
);

    logic                    r_valid   [DEPTH];
    logic                    r_dead    [DEPTH];
    lsu_replay_pkg::cmt_id_t r_cmt_id  [DEPTH];
    lsu_replay_pkg::brmask_t r_br_mask [DEPTH];
    logic                    w_br_kill;
    logic                    w_br_clear;

    assign w_br_kill  = i_br_update & i_br_mispredict;
    assign w_br_clear = i_br_update & ~i_br_mispredict;

    // --------------------
    // Valid and dead marks
    // --------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                r_valid[i] <= 1'b0;
                r_dead[i]  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i_push && (i_push_ptr == lsu_replay_pkg::rq_ptr_t'(i))) begin
                    r_valid[i] <= 1'b1;
                    r_dead[i]  <= 1'b0;
                end else if (i_pop && (i_pop_ptr == lsu_replay_pkg::rq_ptr_t'(i))) begin
                    // A transfer in the flush cycle still completes
                    r_valid[i] <= 1'b0;
                end else if (r_valid[i] &&
                             (i_commit_flush || (w_br_kill && r_br_mask[i][i_br_tag]))) begin
                    r_dead[i] <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // Commit id and mask
    // --------------------
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (i_push && (i_push_ptr == lsu_replay_pkg::rq_ptr_t'(i))) begin
                // New entry keeps the bit even if resolved this cycle
                r_cmt_id[i]  <= i_push_cmt_id;
                r_br_mask[i] <= i_push_br_mask;
            end else if (w_br_clear) begin
                r_br_mask[i][i_br_tag] <= 1'b0;
            end
        end
    end

    assign o_head_dead    = r_valid[i_pop_ptr] & r_dead[i_pop_ptr];
    assign o_head_cmt_id  = r_cmt_id[i_pop_ptr];
    assign o_head_br_mask = r_br_mask[i_pop_ptr];

endmodule

/* design/replay_wakeup.sv */
/*
 * Replay wakeup
 * Pacing counters and the issue decision for the head entry
 */

`timescale 1ns/1ps

module replay_wakeup (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_empty,
    input  logic                      i_pop,
    input  lsu_replay_pkg::haz_t      i_head_typ,
    input  lsu_replay_pkg::missu_oh_t i_head_missu_oh,
    input  lsu_replay_pkg::rq_ptr_t   i_head_gap,
    input  logic                      i_missu_resolve_valid,
    input  lsu_replay_pkg::missu_oh_t i_missu_resolve_oh,
    input  logic                      i_missu_full,
    input  logic                      i_stq_resolve,
    output logic                      o_head_ready,
    output lsu_replay_pkg::rq_ptr_t   o_insert_gap
);

    lsu_replay_pkg::rq_ptr_t r_ins_cnt;
    lsu_replay_pkg::rq_ptr_t r_since_pop;
    logic                    w_pace_hit;

    // --------------------
    // Pacing counters
    // --------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_ins_cnt   <= '0;
            r_since_pop <= '0;
        end else begin
            // Idle queue restarts the gap
            r_ins_cnt   <= i_empty ? '0 : r_ins_cnt + 1'b1;
            r_since_pop <= i_pop ? '0 : r_since_pop + 1'b1;
        end
    end

    assign o_insert_gap = r_ins_cnt;

    // Modulo 8 match on the arrival spacing
    assign w_pace_hit = (i_head_gap != '0) && (r_since_pop == i_head_gap);

    always_comb begin
        o_head_ready = 1'b0;
        if (!i_empty) begin
            if (w_pace_hit) begin
                o_head_ready = 1'b1;
            end else begin
                case (i_head_typ)
                    lsu_replay_pkg::HAZ_STQ_NONFWD,
                    lsu_replay_pkg::HAZ_RMW_ORDER:      o_head_ready = i_stq_resolve;
                    lsu_replay_pkg::HAZ_L1D_CONFLICT:   o_head_ready = 1'b1;
                    lsu_replay_pkg::HAZ_MISSU_FULL:     o_head_ready = ~i_missu_full;
                    lsu_replay_pkg::HAZ_MISSU_ASSIGNED: begin
                        o_head_ready = i_missu_resolve_valid &
                                       (i_missu_resolve_oh == i_head_missu_oh);
                    end
                    default:                            o_head_ready = 1'b0;
                endcase
            end
        end
    end

endmodule

/* design/lsu_replay_queue.sv */
/*
 * LSU replay queue
 * Parks hazarded memory ops and re-issues them as their hazards clear
 */

`timescale 1ns/1ps

`include "lsu_replay_consts.svh"

module lsu_replay_queue #(
    parameter int DEPTH = `LSU_RQ_DEPTH
) (
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    // Hazard input from the pipeline
    input  logic                            i_haz_valid,
    input  lsu_replay_pkg::inst_t           i_haz_inst,
    input  lsu_replay_pkg::paddr_t          i_haz_paddr,
    input  lsu_replay_pkg::haz_t            i_haz_typ,
    input  lsu_replay_pkg::missu_oh_t       i_haz_missu_oh,
    input  lsu_replay_pkg::cmt_id_t         i_haz_cmt_id,
    input  lsu_replay_pkg::brmask_t         i_haz_br_mask,
    output logic                            o_haz_full,
    // Events
    input  logic                            i_commit_flush,
    input  logic                            i_br_update,
    input  logic [$clog2(`LSU_BR_TAGS)-1:0] i_br_tag,
    input  logic                            i_br_mispredict,
    input  logic                            i_missu_resolve_valid,
    input  lsu_replay_pkg::missu_oh_t       i_missu_resolve_oh,
    input  logic                            i_missu_full,
    input  logic                            i_stq_resolve,
    // Replay request to the pipeline
    output logic                            o_req_valid,
    output lsu_replay_pkg::inst_t           o_req_inst,
    output lsu_replay_pkg::paddr_t          o_req_paddr,
    output lsu_replay_pkg::haz_t            o_req_typ,
    output lsu_replay_pkg::missu_oh_t       o_req_missu_oh,
    output lsu_replay_pkg::cmt_id_t         o_req_cmt_id,
    output lsu_replay_pkg::brmask_t         o_req_br_mask,
    input  logic                            i_req_ready
);

    localparam int FIFO_W = $bits(lsu_replay_pkg::inst_t) + $bits(lsu_replay_pkg::paddr_t) +
                            $bits(lsu_replay_pkg::haz_t) + $bits(lsu_replay_pkg::missu_oh_t) +
                            $bits(lsu_replay_pkg::rq_ptr_t);
    localparam lsu_replay_pkg::rq_ptr_t PTR_LAST = lsu_replay_pkg::rq_ptr_t'(DEPTH - 1);

    lsu_replay_pkg::rq_ptr_t r_push_ptr;
    lsu_replay_pkg::rq_ptr_t r_pop_ptr;
    lsu_replay_pkg::rq_ptr_t w_insert_gap;
    lsu_replay_pkg::rq_ptr_t w_head_gap;
    logic [FIFO_W-1:0]       w_wr_data;
    logic [FIFO_W-1:0]       w_rd_data;
    logic                    w_empty;
    logic                    w_full;
    logic                    w_push;
    logic                    w_pop;
    logic                    w_head_ready;
    logic                    w_head_dead;

    // --------------------
    // Handshakes
    // --------------------
    assign o_haz_full  = w_full;
    assign w_push      = i_haz_valid & ~w_full;
    assign o_req_valid = w_head_ready & ~w_head_dead;
    // Dead head drains without a request
    assign w_pop       = (o_req_valid & i_req_ready) | (~w_empty & w_head_dead);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_push_ptr <= '0;
            r_pop_ptr  <= '0;
        end else begin
            if (w_push) begin
                r_push_ptr <= (r_push_ptr == PTR_LAST) ? '0 : r_push_ptr + 1'b1;
            end
            if (w_pop) begin
                r_pop_ptr <= (r_pop_ptr == PTR_LAST) ? '0 : r_pop_ptr + 1'b1;
            end
        end
    end

    // --------------------
    // Payload storage
    // --------------------
    assign w_wr_data = {i_haz_inst, i_haz_paddr, i_haz_typ, i_haz_missu_oh, w_insert_gap};

    ring_fifo #(
        .DEPTH (DEPTH),
        .WIDTH (FIFO_W)
    ) u_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_push),
        .i_data    (w_wr_data),
        .i_pop     (w_pop),
        .o_data    (w_rd_data),
        .o_empty   (w_empty),
        .o_full    (w_full)
    );

    assign {o_req_inst, o_req_paddr, o_req_typ, o_req_missu_oh, w_head_gap} = w_rd_data;

    replay_entry_tags #(
        .DEPTH (DEPTH)
    ) u_tags (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_push          (w_push),
        .i_push_ptr      (r_push_ptr),
        .i_push_cmt_id   (i_haz_cmt_id),
        .i_push_br_mask  (i_haz_br_mask),
        .i_pop           (w_pop),
        .i_pop_ptr       (r_pop_ptr),
        .i_commit_flush  (i_commit_flush),
        .i_br_update     (i_br_update),
        .i_br_tag        (i_br_tag),
        .i_br_mispredict (i_br_mispredict),
        .o_head_dead     (w_head_dead),
        .o_head_cmt_id   (o_req_cmt_id),
        .o_head_br_mask  (o_req_br_mask)
    );

    replay_wakeup u_wakeup (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_empty               (w_empty),
        .i_pop                 (w_pop),
        .i_head_typ            (o_req_typ),
        .i_head_missu_oh       (o_req_missu_oh),
        .i_head_gap            (w_head_gap),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_oh    (i_missu_resolve_oh),
        .i_missu_full          (i_missu_full),
        .i_stq_resolve         (i_stq_resolve),
        .o_head_ready          (w_head_ready),
        .o_insert_gap          (w_insert_gap)
    );

endmodule

/* design/lsu_replay_top.sv */
/*
 * LSU replay top level
 */

`timescale 1ns/1ps

`include "lsu_replay_consts.svh"

module lsu_replay_top (
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  logic                            i_haz_valid,
    input  lsu_replay_pkg::inst_t           i_haz_inst,
    input  lsu_replay_pkg::paddr_t          i_haz_paddr,
    input  lsu_replay_pkg::haz_t            i_haz_typ,
    input  lsu_replay_pkg::missu_oh_t       i_haz_missu_oh,
    input  lsu_replay_pkg::cmt_id_t         i_haz_cmt_id,
    input  lsu_replay_pkg::brmask_t         i_haz_br_mask,
    output logic                            o_haz_full,
    input  logic                            i_commit_flush,
    input  logic                            i_br_update,
    input  logic [$clog2(`LSU_BR_TAGS)-1:0] i_br_tag,
    input  logic                            i_br_mispredict,
    input  logic                            i_missu_resolve_valid,
    input  lsu_replay_pkg::missu_oh_t       i_missu_resolve_oh,
    input  logic                            i_missu_full,
    input  logic                            i_stq_resolve,
    output logic                            o_req_valid,
    output lsu_replay_pkg::inst_t           o_req_inst,
    output lsu_replay_pkg::paddr_t          o_req_paddr,
    output lsu_replay_pkg::haz_t            o_req_typ,
    output lsu_replay_pkg::missu_oh_t       o_req_missu_oh,
    output lsu_replay_pkg::cmt_id_t         o_req_cmt_id,
    output lsu_replay_pkg::brmask_t         o_req_br_mask,
    input  logic                            i_req_ready
);

    lsu_replay_queue #(
        .DEPTH (`LSU_RQ_DEPTH)
    ) u_replay_queue (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_haz_valid           (i_haz_valid),
        .i_haz_inst            (i_haz_inst),
        .i_haz_paddr           (i_haz_paddr),
        .i_haz_typ             (i_haz_typ),
        .i_haz_missu_oh        (i_haz_missu_oh),
        .i_haz_cmt_id          (i_haz_cmt_id),
        .i_haz_br_mask         (i_haz_br_mask),
        .o_haz_full            (o_haz_full),
        .i_commit_flush        (i_commit_flush),
        .i_br_update           (i_br_update),
        .i_br_tag              (i_br_tag),
        .i_br_mispredict       (i_br_mispredict),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_oh    (i_missu_resolve_oh),
        .i_missu_full          (i_missu_full),
        .i_stq_resolve         (i_stq_resolve),
        .o_req_valid           (o_req_valid),
        .o_req_inst            (o_req_inst),
        .o_req_paddr           (o_req_paddr),
        .o_req_typ             (o_req_typ),
        .o_req_missu_oh        (o_req_missu_oh),
        .o_req_cmt_id          (o_req_cmt_id),
        .o_req_br_mask         (o_req_br_mask),
        .i_req_ready           (i_req_ready)
    );

endmodule

/* test/tb_lsu_replay.sv */
/*
 * LSU replay testbench
 * Replays timed records from the data file and scoreboards the re-issued stream
 */

`timescale 1ns/1ps

`include "lsu_replay_consts.svh"

module tb_lsu_replay;

    localparam int MAX_RECS = 256;

    logic                             i_clk;
    logic                             i_reset_n;
    logic                             i_haz_valid;
    lsu_replay_pkg::inst_t            i_haz_inst;
    lsu_replay_pkg::paddr_t           i_haz_paddr;
    lsu_replay_pkg::haz_t             i_haz_typ;
    lsu_replay_pkg::missu_oh_t        i_haz_missu_oh;
    lsu_replay_pkg::cmt_id_t          i_haz_cmt_id;
    lsu_replay_pkg::brmask_t          i_haz_br_mask;
    logic                             o_haz_full;
    logic                             i_commit_flush;
    logic                             i_br_update;
    logic [$clog2(`LSU_BR_TAGS)-1:0]  i_br_tag;
    logic                             i_br_mispredict;
    logic                             i_missu_resolve_valid;
    lsu_replay_pkg::missu_oh_t        i_missu_resolve_oh;
    logic                             i_missu_full;
    logic                             i_stq_resolve;
    logic                             o_req_valid;
    lsu_replay_pkg::inst_t            o_req_inst;
    lsu_replay_pkg::paddr_t           o_req_paddr;
    lsu_replay_pkg::haz_t             o_req_typ;
    lsu_replay_pkg::missu_oh_t        o_req_missu_oh;
    lsu_replay_pkg::cmt_id_t          o_req_cmt_id;
    lsu_replay_pkg::brmask_t          o_req_br_mask;
    logic                             i_req_ready;

    // --------------------
    // Test records
    // --------------------
    byte         rec_op  [MAX_RECS];
    int          rec_cyc [MAX_RECS];
    logic [63:0] rec_f   [MAX_RECS][6];
    int          n_records;
    int          rec_idx;
    int          first_rec;
    logic [1:0]  ready_mode;
    int          xfer_count;
    bit          load_done;

    // Reference queue with the oldest entry first
    lsu_replay_pkg::inst_t     m_inst  [$];
    lsu_replay_pkg::paddr_t    m_paddr [$];
    lsu_replay_pkg::haz_t      m_typ   [$];
    lsu_replay_pkg::missu_oh_t m_missu [$];
    lsu_replay_pkg::cmt_id_t   m_cmt   [$];
    lsu_replay_pkg::brmask_t   m_mask  [$];
    bit                        m_dead  [$];

    lsu_replay_top u_dut (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_haz_valid           (i_haz_valid),
        .i_haz_inst            (i_haz_inst),
        .i_haz_paddr           (i_haz_paddr),
        .i_haz_typ             (i_haz_typ),
        .i_haz_missu_oh        (i_haz_missu_oh),
        .i_haz_cmt_id          (i_haz_cmt_id),
        .i_haz_br_mask         (i_haz_br_mask),
        .o_haz_full            (o_haz_full),
        .i_commit_flush        (i_commit_flush),
        .i_br_update           (i_br_update),
        .i_br_tag              (i_br_tag),
        .i_br_mispredict       (i_br_mispredict),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_oh    (i_missu_resolve_oh),
        .i_missu_full          (i_missu_full),
        .i_stq_resolve         (i_stq_resolve),
        .o_req_valid           (o_req_valid),
        .o_req_inst            (o_req_inst),
        .o_req_paddr           (o_req_paddr),
        .o_req_typ             (o_req_typ),
        .o_req_missu_oh        (o_req_missu_oh),
        .o_req_cmt_id          (o_req_cmt_id),
        .o_req_br_mask         (o_req_br_mask),
        .i_req_ready           (i_req_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic load_records();
        int          fd;
        int          code;
        string       line;
        byte         op;
        int          cyc;
        logic [63:0] f [6];
        fd = $fopen("test/lsu_replay_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file test/lsu_replay_testdata.txt");
            $display("Regression failed");
            $fatal(1);
        end
        n_records = 0;
        while (!$feof(fd) && n_records < MAX_RECS) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] != "#") begin
                code = $sscanf(line, "%c %d %h %h %h %h %h %h",
                               op, cyc, f[0], f[1], f[2], f[3], f[4], f[5]);
                if (code == 8) begin
                    rec_op[n_records]  = op;
                    rec_cyc[n_records] = cyc;
                    for (int j = 0; j < 6; j++) begin
                        rec_f[n_records][j] = f[j];
                    end
                    n_records++;
                end
            end
        end
        $fclose(fd);
        if (n_records == 0) begin
            $display("The data file holds no test records");
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic int first_live();
        for (int k = 0; k < m_dead.size(); k++) begin
            if (!m_dead[k]) begin
                return k;
            end
        end
        return -1;
    endfunction

    // Dead entries ahead of the transfer drained silently
    task automatic retire_through(input int idx);
        for (int k = 0; k <= idx; k++) begin
            void'(m_inst.pop_front());
            void'(m_paddr.pop_front());
            void'(m_typ.pop_front());
            void'(m_missu.pop_front());
            void'(m_cmt.pop_front());
            void'(m_mask.pop_front());
            void'(m_dead.pop_front());
        end
    endtask

    // --------------------
    // Drive one cycle
    // --------------------
    task automatic apply_actions(input int cyc);
        i_haz_valid           <= 1'b0;
        i_commit_flush        <= 1'b0;
        i_br_update           <= 1'b0;
        i_br_mispredict       <= 1'b0;
        i_missu_resolve_valid <= 1'b0;
        i_stq_resolve         <= 1'b0;
        first_rec = rec_idx;
        while (rec_idx < n_records && rec_cyc[rec_idx] == cyc) begin
            case (rec_op[rec_idx])
                "P": begin
                    i_haz_valid    <= 1'b1;
                    i_haz_inst     <= rec_f[rec_idx][0][`LSU_INST_W-1:0];
                    i_haz_paddr    <= rec_f[rec_idx][1][`LSU_PADDR_W-1:0];
                    i_haz_typ      <= lsu_replay_pkg::haz_t'(rec_f[rec_idx][2][2:0]);
                    i_haz_missu_oh <= rec_f[rec_idx][3][`LSU_MISSU_ENTRIES-1:0];
                    i_haz_cmt_id   <= rec_f[rec_idx][4][`LSU_CMT_ID_W-1:0];
                    i_haz_br_mask  <= rec_f[rec_idx][5][`LSU_BR_TAGS-1:0];
                end
                "C": i_commit_flush <= 1'b1;
                "B": begin
                    i_br_update     <= 1'b1;
                    i_br_tag        <= rec_f[rec_idx][0][$clog2(`LSU_BR_TAGS)-1:0];
                    i_br_mispredict <= rec_f[rec_idx][1][0];
                end
                "M": begin
                    i_missu_resolve_valid <= 1'b1;
                    i_missu_resolve_oh    <= rec_f[rec_idx][0][`LSU_MISSU_ENTRIES-1:0];
                end
                "F": i_missu_full <= rec_f[rec_idx][0][0];
                "S": i_stq_resolve <= 1'b1;
                "R": ready_mode = rec_f[rec_idx][0][1:0];
                default: ;
            endcase
            rec_idx++;
        end
        if (ready_mode == 2'd2) begin
            i_req_ready <= ($urandom % 2) == 1;
        end else begin
            i_req_ready <= ready_mode[0];
        end
    endtask

    // --------------------
    // Scoreboard
    // --------------------
    task automatic observe_cycle();
        int                      idx;
        int                      live;
        lsu_replay_pkg::brmask_t mask;
        idx = first_live();
        if (o_req_valid) begin
            check_value("live entry behind o_req_valid", idx >= 0, 1);
            check_value("o_req_inst", o_req_inst, m_inst[idx]);
            check_value("o_req_paddr", o_req_paddr, m_paddr[idx]);
            check_value("o_req_typ", o_req_typ, m_typ[idx]);
            check_value("o_req_missu_oh", o_req_missu_oh, m_missu[idx]);
            check_value("o_req_cmt_id", o_req_cmt_id, m_cmt[idx]);
            check_value("o_req_br_mask", o_req_br_mask, m_mask[idx]);
            if (i_req_ready) begin
                retire_through(idx);
                xfer_count++;
            end
        end
        // Flush marks apply to entries present before this cycle's push
        for (int k = 0; k < m_dead.size(); k++) begin
            mask = m_mask[k];
            if (i_commit_flush || (i_br_update && i_br_mispredict && mask[i_br_tag])) begin
                m_dead[k] = 1'b1;
            end
            if (i_br_update && !i_br_mispredict) begin
                mask[i_br_tag] = 1'b0;
                m_mask[k] = mask;
            end
        end
        if (i_haz_valid) begin
            m_inst.push_back(i_haz_inst);
            m_paddr.push_back(i_haz_paddr);
            m_typ.push_back(i_haz_typ);
            m_missu.push_back(i_haz_missu_oh);
            m_cmt.push_back(i_haz_cmt_id);
            m_mask.push_back(i_haz_br_mask);
            m_dead.push_back(1'b0);
        end
        for (int k = first_rec; k < rec_idx; k++) begin
            case (rec_op[k])
                "V": check_value("o_req_valid", o_req_valid, rec_f[k][0]);
                "H": check_value("o_haz_full", o_haz_full, rec_f[k][0]);
                "E": begin
                    live = 0;
                    foreach (m_dead[j]) begin
                        live += m_dead[j] ? 0 : 1;
                    end
                    check_value("transfer count", xfer_count, rec_f[k][0]);
                    check_value("live entries left", live, 0);
                end
                default: ;
            endcase
        end
    endtask

    initial begin : watchdog
        longint limit_ns;
        wait (load_done);
        limit_ns = (longint'(n_records) * 64 + 8) * 40;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Regression failed");
        $fatal(1);
    end

    initial begin : main
        int unsigned seed;
        int          last_cycle;
        i_reset_n             = 1'b0;
        i_haz_valid           = 1'b0;
        i_haz_inst            = '0;
        i_haz_paddr           = '0;
        i_haz_typ             = lsu_replay_pkg::HAZ_STQ_NONFWD;
        i_haz_missu_oh        = '0;
        i_haz_cmt_id          = '0;
        i_haz_br_mask         = '0;
        i_commit_flush        = 1'b0;
        i_br_update           = 1'b0;
        i_br_tag              = '0;
        i_br_mispredict       = 1'b0;
        i_missu_resolve_valid = 1'b0;
        i_missu_resolve_oh    = '0;
        i_missu_full          = 1'b0;
        i_stq_resolve         = 1'b0;
        i_req_ready           = 1'b0;
        ready_mode            = 2'd0;
        xfer_count            = 0;
        rec_idx               = 0;
        first_rec             = 0;
        seed = $urandom(34053);
        load_records();
        last_cycle = rec_cyc[n_records-1];
        load_done = 1'b1;
        repeat (8) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);
        check_value("o_haz_full after reset", o_haz_full, 0);
        check_value("o_req_valid after reset", o_req_valid, 0);
        for (int cyc = 0; cyc <= last_cycle; cyc++) begin
            @(posedge i_clk);
            apply_actions(cyc);
            @(negedge i_clk);
            observe_cycle();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* test/lsu_replay_testdata.txt */
# op cycle f0 f1 f2 f3 f4 f5 (fields hex), P: inst paddr typ missu_oh cmt_id br_mask
# C flush, B tag mispredict, M oh, F level, S, R ready 0/1/2=random, V/H/E expect
R 0 2 0 0 0 0 0
P 2 00a12083 0000c1040 2 0 01 0
P 3 00b12183 1000c1080 2 0 02 1
P 4 0042a023 2abcd0100 2 0 03 0
P 5 fe812e23 3fffffffc 2 0 04 8
P 6 00852503 012345678 2 0 05 2
P 7 0005b583 300000000 2 0 06 0
R 40 1 0 0 0 0 0
F 50 1 0 0 0 0 0
P 50 00c13083 000200040 3 0 07 0
V 56 0 0 0 0 0 0
F 60 0 0 0 0 0 0
V 60 1 0 0 0 0 0
P 70 01013103 000200080 4 2 08 0
M 74 4 0 0 0 0 0
V 74 0 0 0 0 0 0
M 78 2 0 0 0 0 0
V 78 1 0 0 0 0 0
P 90 0062a023 000300000 0 0 09 0
V 96 0 0 0 0 0 0
S 100 0 0 0 0 0 0
V 100 1 0 0 0 0 0
P 110 1007a0af 000300010 1 0 0a 0
V 113 0 0 0 0 0 0
S 118 0 0 0 0 0 0
V 118 1 0 0 0 0 0
F 130 1 0 0 0 0 0
P 130 00412283 000400000 3 0 0b 0
P 131 00812303 000400040 3 0 0c 0
P 132 00c12383 000400080 3 0 0d 0
V 135 0 0 0 0 0 0
C 136 0 0 0 0 0 0
F 138 0 0 0 0 0 0
V 139 0 0 0 0 0 0
P 150 01412403 000500000 2 0 0e 0
V 151 1 0 0 0 0 0
R 170 0 0 0 0 0 0
P 170 02012483 000600000 2 0 10 1
P 171 02412503 000600040 2 0 11 2
P 172 02812583 000600080 2 0 12 3
P 173 02c12603 0006000c0 2 0 13 4
B 176 1 1 0 0 0 0
B 178 0 0 0 0 0 0
B 180 2 0 0 0 0 0
P 180 03012683 000600100 2 0 14 4
R 184 1 0 0 0 0 0
V 185 0 0 0 0 0 0
V 187 1 0 0 0 0 0
R 200 0 0 0 0 0 0
P 200 04012703 000700000 2 0 20 0
P 201 04412783 000700040 2 0 21 0
P 202 04812803 000700080 2 0 22 0
P 203 04c12883 0007000c0 2 0 23 0
P 204 05012903 000700100 2 0 24 0
P 205 05412983 000700140 2 0 25 0
P 206 05812a03 000700180 2 0 26 0
P 207 05c12a83 0007001c0 2 0 27 0
H 207 0 0 0 0 0 0
H 208 1 0 0 0 0 0
R 210 1 0 0 0 0 0
R 211 0 0 0 0 0 0
H 211 0 0 0 0 0 0
P 212 06012b03 000700200 2 0 28 0
H 213 1 0 0 0 0 0
V 213 1 0 0 0 0 0
R 216 2 0 0 0 0 0
E 300 17 0 0 0 0 0

/* filelist.f */
+incdir+design
design/lsu_replay_pkg.sv
design/ring_fifo.sv
design/replay_entry_tags.sv
design/replay_wakeup.sv
design/lsu_replay_queue.sv
design/lsu_replay_top.sv
test/tb_lsu_replay.sv

/* Bender.yml */
package:
  name: lsu_replay

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_replay_pkg.sv
      - design/ring_fifo.sv
      - design/replay_entry_tags.sv
      - design/replay_wakeup.sv
      - design/lsu_replay_queue.sv
      - design/lsu_replay_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/tb_lsu_replay.sv
